/* src/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    // Data word as seen by the register file and the ALU
    typedef logic [31:0] word_t;

    // Instruction address, same width as a word in RV32I
    typedef logic [31:0] addr_t;

    // Architectural register number, x0 to x31
    typedef logic [4:0] regaddr_t;

    // ALU operations, arithmetic and logic first, then the PC-relative ones
    typedef enum logic [3:0] {
        OP_ADD   = 4'd0,
        OP_SUB   = 4'd1,
        OP_SLL   = 4'd2,
        OP_SLT   = 4'd3,
        OP_SLTU  = 4'd4,
        OP_XOR   = 4'd5,
        OP_SRL   = 4'd6,
        OP_SRA   = 4'd7,
        OP_OR    = 4'd8,
        OP_AND   = 4'd9,
        OP_LUI   = 4'd10,
        OP_AUIPC = 4'd11,
        OP_JAL   = 4'd12,
        OP_JALR  = 4'd13
    } alu_op_e;

endpackage

`default_nettype wire

/* src/sched_pkg.sv */
`default_nettype none

package sched_pkg;

    // Producer tag, zero is reserved
    typedef logic [3:0] tag_t;

    // Operand already holds its value
    localparam tag_t TAG_READY = 4'd0;

    // One reservation station slot
    typedef struct packed {
        isa_pkg::alu_op_e op;
        isa_pkg::addr_t   pc;
        tag_t             tag_x;
        isa_pkg::word_t   data_x;
        tag_t             tag_y;
        isa_pkg::word_t   data_y;
        tag_t             tag;
        isa_pkg::regaddr_t rd;
    } rs_entry_t;

endpackage

`default_nettype wire

/* src/alu_issue_if.sv */
`default_nettype none
`timescale 1ns/1ps

interface alu_issue_if;
    import isa_pkg::*;
    import sched_pkg::*;

    logic     valid;
    alu_op_e  op;
    addr_t    pc;
    word_t    data_x;
    word_t    data_y;
    // Destination tag of the issued operation
    tag_t     tag;
    regaddr_t rd;

    modport station (
        output valid, op, pc, data_x, data_y, tag, rd
    );

    modport alu (
        input valid, op, pc, data_x, data_y, tag, rd
    );

endinterface

`default_nettype wire

/* src/cdb_if.sv */
`default_nettype none
`timescale 1ns/1ps

interface cdb_if;
    import isa_pkg::*;
    import sched_pkg::*;

    logic     valid;
    tag_t     tag;
    regaddr_t rd;
    word_t    data;
    logic     jump;
    addr_t    jump_addr;

    modport alu (output valid, tag, rd, data, jump, jump_addr);

    modport wb (output valid, tag, rd, data, jump, jump_addr);

    modport snoop (input valid, tag, rd, data, jump, jump_addr);

endinterface

`default_nettype wire

/* src/alu_station.sv */
`default_nettype none
`timescale 1ns/1ps

module alu_station #(
    parameter int RS_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 disp_valid,
    input  sched_pkg::rs_entry_t disp_entry,
    output logic                 rs_full,
    cdb_if.snoop                 bus,
    alu_issue_if.station         issue
);
    import sched_pkg::*;

    rs_entry_t           slot [RS_DEPTH];
    logic [RS_DEPTH-1:0] busy;
    // older[i][j] set when slot i was dispatched before slot j
    logic [RS_DEPTH-1:0] older [RS_DEPTH];
    logic [RS_DEPTH-1:0] ready;
    logic [RS_DEPTH-1:0] grant;
    logic [RS_DEPTH-1:0] alloc;
    logic                flush;
    logic                accept;
    rs_entry_t           pick;
    rs_entry_t           incoming;

    function automatic logic wake(input tag_t t);
        return bus.valid && (t != TAG_READY) && (t == bus.tag);
    endfunction

    // A jump broadcast means the remaining entries are on the wrong path
    assign flush   = bus.valid && bus.jump;
    assign rs_full = &busy;
    assign accept  = disp_valid && !rs_full && !flush;

    // Lowest free slot
    assign alloc = ~busy & (busy + 1'b1);

    // Dispatched operands can be woken by the broadcast of the same cycle
    always_comb begin
        incoming = disp_entry;
        if (wake(disp_entry.tag_x)) begin
            incoming.tag_x  = TAG_READY;
            incoming.data_x = bus.data;
        end
        if (wake(disp_entry.tag_y)) begin
            incoming.tag_y  = TAG_READY;
            incoming.data_y = bus.data;
        end
    end

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            ready[i] = busy[i] && (slot[i].tag_x == TAG_READY)
                       && (slot[i].tag_y == TAG_READY);
        end
    end

    // Oldest ready entry wins
    always_comb begin
        grant = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            grant[i] = ready[i];
            for (int j = 0; j < RS_DEPTH; j++) begin
                if (ready[j] && older[j][i]) begin
                    grant[i] = 1'b0;
                end
            end
        end
    end

    always_comb begin
        pick = slot[0];
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (grant[i]) begin
                pick = slot[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy        <= '0;
            issue.valid <= 1'b0;
            for (int i = 0; i < RS_DEPTH; i++) begin
                older[i] <= '0;
            end
        end else if (flush) begin
            busy        <= '0;
            issue.valid <= 1'b0;
        end else begin
            issue.valid <= |grant;
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (grant[i]) begin
                    busy[i] <= 1'b0;
                end
                if (accept && alloc[i]) begin
                    busy[i]  <= 1'b1;
                    older[i] <= '0;
                    // Everything else is older than the newcomer
                    for (int j = 0; j < RS_DEPTH; j++) begin
                        if (j != i) begin
                            older[j][i] <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        issue.op     <= pick.op;
        issue.pc     <= pick.pc;
        issue.data_x <= pick.data_x;
        issue.data_y <= pick.data_y;
        issue.tag    <= pick.tag;
        issue.rd     <= pick.rd;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (accept && alloc[i]) begin
                slot[i] <= incoming;
            end else begin
                if (wake(slot[i].tag_x)) begin
                    slot[i].tag_x  <= TAG_READY;
                    slot[i].data_x <= bus.data;
                end
                if (wake(slot[i].tag_y)) begin
                    slot[i].tag_y  <= TAG_READY;
                    slot[i].data_y <= bus.data;
                end
            end
        end
    end

    a_no_disp_full: assert property (
        @(posedge clk) disable iff (!rst_n) disp_valid |-> !rs_full
    );

    // Only a fully woken entry may leave, and the age order names a single winner
    a_issue_ready: assert property (
        @(posedge clk) disable iff (!rst_n)
        (|grant) |-> $onehot(grant) && (pick.tag_x == TAG_READY)
                     && (pick.tag_y == TAG_READY)
    );

    a_alloc_onehot: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0(alloc)
    );

endmodule

`default_nettype wire

/* src/ex_alu.sv */
`default_nettype none
`timescale 1ns/1ps

module ex_alu (
    input  logic     clk,
    input  logic     rst_n,
    alu_issue_if.alu issue,
    cdb_if.alu       result
);
    import isa_pkg::*;

    word_t data_c;
    addr_t target_c;
    logic  jump_c;

    always_comb begin
        data_c   = '0;
        target_c = '0;
        jump_c   = 1'b0;
        case (issue.op)
            OP_ADD:  data_c = issue.data_x + issue.data_y;
            OP_SUB:  data_c = issue.data_x - issue.data_y;
            OP_SLL:  data_c = issue.data_x << issue.data_y[4:0];
            OP_SLT: begin
                data_c = {31'd0, $signed(issue.data_x) < $signed(issue.data_y)};
            end
            OP_SLTU: data_c = {31'd0, issue.data_x < issue.data_y};
            OP_XOR:  data_c = issue.data_x ^ issue.data_y;
            OP_SRL:  data_c = issue.data_x >> issue.data_y[4:0];
            OP_SRA:  data_c = $signed(issue.data_x) >>> issue.data_y[4:0];
            OP_OR:   data_c = issue.data_x | issue.data_y;
            OP_AND:  data_c = issue.data_x & issue.data_y;
            // Upper immediate arrives already shifted in x
            OP_LUI:   data_c = issue.data_x;
            OP_AUIPC: data_c = issue.data_x + issue.pc;
            OP_JAL: begin
                data_c   = issue.pc + 32'd4;
                target_c = issue.pc + issue.data_x;
                jump_c   = 1'b1;
            end
            OP_JALR: begin
                data_c   = issue.pc + 32'd4;
                target_c = (issue.data_x + issue.data_y) & 32'hffff_fffe;
                jump_c   = 1'b1;
            end
            default: begin
                data_c = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result.valid <= 1'b0;
            result.jump  <= 1'b0;
        end else begin
            result.valid <= issue.valid;
            result.jump  <= issue.valid && jump_c;
        end
    end

    always_ff @(posedge clk) begin
        result.tag       <= issue.tag;
        result.rd        <= issue.rd;
        result.data      <= data_c;
        result.jump_addr <= target_c;
    end

    a_jalr_even: assert property (
        @(posedge clk) disable iff (!rst_n)
        issue.valid && (issue.op == OP_JALR) |=> result.jump && !result.jump_addr[0]
    );

endmodule

`default_nettype wire

/* src/alu_writeback.sv */
`default_nettype none
`timescale 1ns/1ps

module alu_writeback (
    input  logic              clk,
    input  logic              rst_n,
    cdb_if.wb                 result,
    cdb_if.wb                 bus,
    output logic              rf_we,
    output isa_pkg::regaddr_t rf_addr,
    output isa_pkg::word_t    rf_data,
    output logic              redirect,
    output isa_pkg::addr_t    redirect_addr
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus.valid <= 1'b0;
            rf_we     <= 1'b0;
            redirect  <= 1'b0;
        end else begin
            bus.valid <= result.valid;
            // x0 is never written
            rf_we     <= result.valid && (result.rd != '0);
            redirect  <= result.valid && result.jump;
        end
    end

    always_ff @(posedge clk) begin
        bus.tag       <= result.tag;
        bus.rd        <= result.rd;
        bus.data      <= result.data;
        redirect_addr <= result.jump_addr;
    end

    // Register write shares the broadcast payload
    assign rf_addr = bus.rd;
    assign rf_data = bus.data;

    // Station sees the redirect as a jump on the broadcast
    assign bus.jump      = redirect;
    assign bus.jump_addr = redirect_addr;

    a_redirect_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        redirect |-> bus.valid && $past(result.valid && result.jump)
    );

endmodule

`default_nettype wire

/* src/alu_cluster_top.sv */
`default_nettype none
`timescale 1ns/1ps

module alu_cluster_top #(
    parameter int RS_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst_n,

    input  logic              disp_valid,
    input  isa_pkg::alu_op_e  disp_op,
    input  isa_pkg::addr_t    disp_pc,
    input  sched_pkg::tag_t   disp_tag_x,
    input  isa_pkg::word_t    disp_data_x,
    input  sched_pkg::tag_t   disp_tag_y,
    input  isa_pkg::word_t    disp_data_y,
    input  sched_pkg::tag_t   disp_tag,
    input  isa_pkg::regaddr_t disp_rd,

    output logic              rs_full,
    output logic              rf_we,
    output isa_pkg::regaddr_t rf_addr,
    output isa_pkg::word_t    rf_data,
    output logic              res_valid,
    output sched_pkg::tag_t   res_tag,
    output isa_pkg::word_t    res_data,
    output logic              redirect,
    output isa_pkg::addr_t    redirect_addr
);
    import sched_pkg::*;

    rs_entry_t disp_entry;

    alu_issue_if issue_if ();
    // ALU to writeback
    cdb_if       result_if ();
    // Writeback broadcast, snooped by the station
    cdb_if       bus_if ();

    assign disp_entry = '{
        op:     disp_op,
        pc:     disp_pc,
        tag_x:  disp_tag_x,
        data_x: disp_data_x,
        tag_y:  disp_tag_y,
        data_y: disp_data_y,
        tag:    disp_tag,
        rd:     disp_rd
    };

    assign res_valid = bus_if.valid;
    assign res_tag   = bus_if.tag;
    assign res_data  = bus_if.data;

    alu_station #(
        .RS_DEPTH (RS_DEPTH)
    ) alu_station_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .disp_valid (disp_valid),
        .disp_entry (disp_entry),
        .rs_full    (rs_full),
        .bus        (bus_if.snoop),
        .issue      (issue_if.station)
    );

    ex_alu ex_alu_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .issue  (issue_if.alu),
        .result (result_if.alu)
    );

    alu_writeback alu_writeback_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .result        (result_if.wb),
        .bus           (bus_if.wb),
        .rf_we         (rf_we),
        .rf_addr       (rf_addr),
        .rf_data       (rf_data),
        .redirect      (redirect),
        .redirect_addr (redirect_addr)
    );

endmodule

`default_nettype wire

/* bench/alu_model.svh */
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// Expected outcome of one ALU operation, worked out from the RV32I rules
function automatic void alu_model(
    input  alu_op_e op,
    input  addr_t   pc,
    input  word_t   x,
    input  word_t   y,
    output word_t   data,
    output logic    jump,
    output addr_t   target
);
    logic [4:0] shamt;
    shamt  = y[4:0];
    data   = '0;
    jump   = 1'b0;
    target = '0;
    case (op)
        OP_ADD:   data = x + y;
        OP_SUB:   data = x + ~y + 32'd1;
        OP_SLL:   data = x << shamt;
        // Differing signs decide by the sign of x alone
        OP_SLT:   data = (x[31] != y[31]) ? {31'd0, x[31]} : {31'd0, x < y};
        OP_SLTU:  data = {31'd0, x < y};
        OP_XOR:   data = x ^ y;
        OP_SRL:   data = x >> shamt;
        OP_SRA:   data = (x >> shamt) | (x[31] ? ~(32'hffff_ffff >> shamt) : 32'd0);
        OP_OR:    data = x | y;
        OP_AND:   data = x & y;
        OP_LUI:   data = x;
        OP_AUIPC: data = pc + x;
        OP_JAL: begin
            data   = pc + 32'd4;
            jump   = 1'b1;
            target = pc + x;
        end
        OP_JALR: begin
            data   = pc + 32'd4;
            jump   = 1'b1;
            target = {x[31:1] + y[31:1] + {30'd0, x[0] & y[0]}, 1'b0};
        end
        default: data = '0;
    endcase
endfunction

`endif

/* bench/tb_alu_cluster.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_alu_cluster;
    import isa_pkg::*;
    import sched_pkg::*;

    `include "alu_model.svh"

    localparam int N_RANDOM = 200;
    // One jump, four waiting entries and four refills per flush round
    localparam int N_FLUSH_OPS = 9;
    localparam int TOTAL_OPS = N_RANDOM + 2 * N_FLUSH_OPS;
    localparam int MAX_CYCLES = 40 * TOTAL_OPS;
    // Never a destination, so an entry waiting on it leaves only through a flush
    localparam tag_t NO_PRODUCER = 4'd15;

    logic     clk;
    logic     rst_n;
    logic     disp_valid;
    alu_op_e  disp_op;
    addr_t    disp_pc;
    tag_t     disp_tag_x;
    word_t    disp_data_x;
    tag_t     disp_tag_y;
    word_t    disp_data_y;
    tag_t     disp_tag;
    regaddr_t disp_rd;
    logic     rs_full;
    logic     rf_we;
    regaddr_t rf_addr;
    word_t    rf_data;
    logic     res_valid;
    tag_t     res_tag;
    word_t    res_data;
    logic     redirect;
    addr_t    redirect_addr;

    // Scoreboard indexed by destination tag
    word_t       exp_data [16];
    regaddr_t    exp_rd [16];
    logic        exp_jump [16];
    addr_t       exp_target [16];
    logic        pending [16];
    logic        in_use [16];
    int          outstanding;
    int          checked;
    int          cycles = 0;
    logic [31:0] rng = 32'h5cdb_bff8;

    alu_cluster_top #(
        .RS_DEPTH (4)
    ) alu_cluster_top_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .disp_valid    (disp_valid),
        .disp_op       (disp_op),
        .disp_pc       (disp_pc),
        .disp_tag_x    (disp_tag_x),
        .disp_data_x   (disp_data_x),
        .disp_tag_y    (disp_tag_y),
        .disp_data_y   (disp_data_y),
        .disp_tag      (disp_tag),
        .disp_rd       (disp_rd),
        .rs_full       (rs_full),
        .rf_we         (rf_we),
        .rf_addr       (rf_addr),
        .rf_data       (rf_data),
        .res_valid     (res_valid),
        .res_tag       (res_tag),
        .res_data      (res_data),
        .redirect      (redirect),
        .redirect_addr (redirect_addr)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        rng = xorshift32(rng);
        r = rng;
    endtask

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic find_free_tag(output tag_t t, output logic ok);
        ok = 1'b0;
        t  = TAG_READY;
        for (int i = 1; i < 15; i++) begin
            if (!ok && !in_use[i]) begin
                t  = tag_t'(i);
                ok = 1'b1;
            end
        end
        if (ok) begin
            in_use[t] = 1'b1;
        end
    endtask

    task automatic pick_pending(output tag_t t, output logic ok);
        logic [31:0] r;
        int          idx;
        next_rand(r);
        t  = TAG_READY;
        ok = 1'b0;
        for (int i = 0; i < 14; i++) begin
            idx = 1 + ((int'(r[3:0]) + i) % 14);
            if (!ok && pending[idx]) begin
                t  = tag_t'(idx);
                ok = 1'b1;
            end
        end
    endtask

    // A tagged operand carries junk data, the model takes the producer's result
    task automatic make_operand(input logic allow_dep, output tag_t t,
                                output word_t driven, output word_t value);
        logic [31:0] r;
        logic [31:0] s;
        tag_t        p;
        logic        ok;
        next_rand(r);
        next_rand(s);
        t      = TAG_READY;
        driven = r;
        value  = r;
        ok     = 1'b0;
        p      = TAG_READY;
        if (allow_dep && s[1:0] == 2'd0) begin
            pick_pending(p, ok);
        end
        if (ok) begin
            t     = p;
            value = exp_data[p];
        end
    endtask

    task automatic record_expected(input tag_t tag, input alu_op_e op, input addr_t pc,
                                   input word_t x, input word_t y, input regaddr_t rd);
        word_t d;
        logic  j;
        addr_t tg;
        alu_model(op, pc, x, y, d, j, tg);
        exp_data[tag]   = d;
        exp_jump[tag]   = j;
        exp_target[tag] = tg;
        exp_rd[tag]     = rd;
        pending[tag]    = 1'b1;
        outstanding++;
    endtask

    task automatic drive_dispatch(input alu_op_e op, input addr_t pc, input tag_t tx,
                                  input word_t dx, input tag_t ty, input word_t dy,
                                  input tag_t tag, input regaddr_t rd);
        disp_valid  <= 1'b1;
        disp_op     <= op;
        disp_pc     <= pc;
        disp_tag_x  <= tx;
        disp_data_x <= dx;
        disp_tag_y  <= ty;
        disp_data_y <= dy;
        disp_tag    <= tag;
        disp_rd     <= rd;
    endtask

    task automatic send_random_op(input tag_t tag, input tag_t dep);
        logic [31:0] r;
        logic [31:0] s;
        alu_op_e     op;
        addr_t       pc;
        regaddr_t    rd;
        tag_t        tx;
        tag_t        ty;
        word_t       dx;
        word_t       dy;
        word_t       vx;
        word_t       vy;
        next_rand(r);
        next_rand(s);
        op = alu_op_e'(4'(r[7:0] % 8'd12));
        pc = s & 32'hffff_fffc;
        rd = (r[10:8] == 3'd0) ? 5'd0 : r[15:11];
        make_operand(dep == TAG_READY, tx, dx, vx);
        if (dep != TAG_READY) begin
            tx = dep;
            vx = exp_data[dep];
        end
        make_operand(1'b1, ty, dy, vy);
        record_expected(tag, op, pc, vx, vy, rd);
        drive_dispatch(op, pc, tx, dx, ty, dy, tag, rd);
    endtask

    task automatic send_waiter(input tag_t tag);
        logic [31:0] r;
        logic [31:0] s;
        next_rand(r);
        next_rand(s);
        drive_dispatch(alu_op_e'(4'(r[7:0] % 8'd12)), s & 32'hffff_fffc, NO_PRODUCER, r,
                       TAG_READY, s, tag, r[20:16]);
    endtask

    task automatic send_jump(input tag_t tag, input alu_op_e op);
        logic [31:0] r;
        logic [31:0] s;
        logic [31:0] u;
        addr_t       pc;
        regaddr_t    rd;
        next_rand(r);
        next_rand(s);
        next_rand(u);
        pc = u & 32'hffff_fffc;
        // JALR goes to x0 like a plain return
        rd = (op == OP_JALR) ? 5'd0 : (r[4:0] | 5'd1);
        record_expected(tag, op, pc, r, s, rd);
        drive_dispatch(op, pc, TAG_READY, r, TAG_READY, s, tag, rd);
    endtask

    // At most every other cycle, so a sampled low rs_full still holds at the edge
    task automatic run_random(input int count);
        logic [31:0] r;
        tag_t        t;
        logic        ok;
        logic        last;
        int          sent;
        sent = 0;
        last = 1'b0;
        while (sent < count) begin
            @(posedge clk);
            next_rand(r);
            ok = 1'b0;
            if (!rs_full && !last && r[1:0] != 2'd0) begin
                find_free_tag(t, ok);
            end
            if (ok) begin
                send_random_op(t, TAG_READY);
                sent++;
            end else begin
                disp_valid <= 1'b0;
            end
            last = ok;
        end
        @(posedge clk);
        disp_valid <= 1'b0;
    endtask

    task automatic flush_round(input alu_op_e jop);
        tag_t t;
        tag_t prev;
        tag_t held [4];
        logic ok;
        logic saw_full;
        int   waiters;
        saw_full = 1'b0;
        @(posedge clk);
        find_free_tag(t, ok);
        check(ok, 1'b1, "free tag for a waiting entry");
        held[0] = t;
        send_waiter(t);
        waiters = 1;
        @(posedge clk);
        find_free_tag(t, ok);
        check(ok, 1'b1, "free tag for the jump");
        send_jump(t, jop);
        while (waiters < 4) begin
            @(posedge clk);
            check(redirect, 1'b0, "redirect before the station filled");
            if (!rs_full) begin
                find_free_tag(t, ok);
                check(ok, 1'b1, "free tag for a waiting entry");
                held[waiters] = t;
                send_waiter(t);
                waiters++;
            end else begin
                disp_valid <= 1'b0;
            end
        end
        do begin
            @(posedge clk);
            disp_valid <= 1'b0;
            if (rs_full) begin
                saw_full = 1'b1;
            end
        end while (!redirect);
        check(saw_full, 1'b1, "rs_full with four waiting entries");
        @(posedge clk);
        check(rs_full, 1'b0, "rs_full after the flush");
        for (int i = 0; i < 4; i++) begin
            in_use[held[i]] = 1'b0;
        end
        // Refill with a chain, each op waiting on the one before
        prev = TAG_READY;
        for (int i = 0; i < 4; i++) begin
            if (i > 0) begin
                @(posedge clk);
            end
            check(rs_full, 1'b0, "rs_full while refilling");
            find_free_tag(t, ok);
            check(ok, 1'b1, "free tag for a refill");
            send_random_op(t, prev);
            prev = t;
        end
        @(posedge clk);
        disp_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        while (outstanding != 0) begin
            @(posedge clk);
        end
    endtask

    always @(negedge clk) begin : compare_results
        tag_t t;
        if (rst_n) begin
            if (res_valid) begin
                t = res_tag;
                check(pending[t], 1'b1, "result for a tag that is not outstanding");
                check(res_data, exp_data[t], "res_data");
                check(rf_we, exp_rd[t] != 5'd0, "rf_we against rd");
                if (exp_rd[t] != 5'd0) begin
                    check(rf_addr, exp_rd[t], "rf_addr");
                    check(rf_data, exp_data[t], "rf_data");
                end
                check(redirect, exp_jump[t], "redirect");
                if (exp_jump[t]) begin
                    check(redirect_addr, exp_target[t], "redirect_addr");
                end
                pending[t] = 1'b0;
                in_use[t]  = 1'b0;
                outstanding--;
                checked++;
            end else begin
                check(rf_we, 1'b0, "rf_we without a result");
                check(redirect, 1'b0, "redirect without a result");
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, %0d operations still outstanding",
                     cycles, outstanding);
            for (int i = 1; i < 16; i++) begin
                if (pending[i]) begin
                    $display("Tag %0d never completed", i);
                end
            end
            $display("TEST FAILED");
            $fatal(1, "simulation ran out of cycles");
        end
    end

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        disp_valid  = 1'b0;
        disp_op     = OP_ADD;
        disp_pc     = '0;
        disp_tag_x  = TAG_READY;
        disp_data_x = '0;
        disp_tag_y  = TAG_READY;
        disp_data_y = '0;
        disp_tag    = TAG_READY;
        disp_rd     = '0;
        outstanding = 0;
        checked     = 0;
        for (int i = 0; i < 16; i++) begin
            exp_data[i]   = '0;
            exp_rd[i]     = '0;
            exp_jump[i]   = 1'b0;
            exp_target[i] = '0;
            pending[i]    = 1'b0;
            in_use[i]     = 1'b0;
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        check(rs_full, 1'b0, "rs_full after reset");
        check(res_valid, 1'b0, "res_valid after reset");
        check(rf_we, 1'b0, "rf_we after reset");
        check(redirect, 1'b0, "redirect after reset");

        run_random(N_RANDOM);
        wait_drain();
        flush_round(OP_JAL);
        wait_drain();
        flush_round(OP_JALR);
        wait_drain();

        $display("%0d results checked", checked);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+bench
src/isa_pkg.sv
src/sched_pkg.sv
src/alu_issue_if.sv
src/cdb_if.sv
src/alu_station.sv
src/ex_alu.sv
src/alu_writeback.sv
src/alu_cluster_top.sv
bench/tb_alu_cluster.sv

/* Makefile */
TOP = tb_alu_cluster

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f filelist.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
